// File: src/ksCromPkg.sv
`default_nettype none

package ksCromPkg;

   ////////////////////////////////
   // Microword layout
   ////////////////////////////////

   // Control ROM word, big-endian numbering 0 to 23
   localparam int cromWidth = 24;

   // Microaddress sits in bits 0-11, LSB at bit 11
   localparam int cromAddrWidth = 12;
   localparam int cromAddrLsb   = 11;

   // DBUS select in bits 12-13
   localparam int cromDbusSel  = 12;
   localparam int cromSelWidth = 2;

   // Ramfile address in bits 14-17
   localparam int cromRamAddr = 14;

   // Write-back flag, bits 19-23 are spare
   localparam int cromRamWrite = 18;

   typedef logic [0:cromAddrWidth-1] cromAddr_t;
   typedef logic [0:cromSelWidth-1]  dbusSel_t;

   ////////////////////////////////
   // DBUS select codes
   ////////////////////////////////

   localparam dbusSel_t dbusSelFlags   = 2'd0;
   localparam dbusSel_t dbusSelDp      = 2'd1;
   localparam dbusSel_t dbusSelRamfile = 2'd2;
   localparam dbusSel_t dbusSelDbm     = 2'd3;

   // Microaddresses that never force the ramfile on an AC reference
   localparam cromAddr_t noForceAddr0 = 12'o1146;
   localparam cromAddr_t noForceAddr1 = 12'o3666;
   localparam cromAddr_t noForceAddr2 = 12'o1060;
   localparam cromAddr_t noForceAddr3 = 12'o3722;

endpackage

`default_nettype wire

// File: src/ksDataPkg.sv
`default_nettype none

package ksDataPkg;

   // Full 36-bit machine word, bit 0 is the MSB
   typedef logic [0:35] word_t;

   // Left half word for the PC flags
   typedef logic [0:17] pcFlags_t;

   ////////////////////////////////
   // VMA register views
   ////////////////////////////////

   // Flag bits 0-13, then the 22-bit address
   typedef struct packed
   {
      logic        user;
      logic        fetch;
      logic        read;        // Flag bit 2
      logic        writeTest;
      logic        write;
      logic        cacheInh;
      logic        physical;
      logic        previous;
      logic        io;
      logic        wru;
      logic        vector;
      logic        ioByte;
      logic        acRef;       // Flag bit 12
      logic        spare;
      logic [0:21] addr;
   } vmaFields_t;

   // Same 36 bits read as flags or as a plain word
   typedef union packed
   {
      word_t      raw;
      vmaFields_t f;
   } vmaWord_t;

   ////////////////////////////////
   // Ramfile geometry
   ////////////////////////////////

   localparam int ramDepth     = 16;
   localparam int ramAddrWidth = $clog2(ramDepth);

   typedef logic [0:ramAddrWidth-1] ramAddr_t;

endpackage

`default_nettype wire

// File: src/dbusDecode.sv
`default_nettype none

module dbusDecode
(
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              advance,
   input  wire                              inValid,
   input  wire  [0:ksCromPkg::cromWidth-1]  crom,
   input  wire                              cacheHit,
   input  wire  [0:2]                       piReqPri,
   input  wire  ksDataPkg::vmaWord_t        vmaReg,
   input  wire  ksDataPkg::pcFlags_t        pcFlags,
   input  wire  ksDataPkg::word_t           dp,
   input  wire  ksDataPkg::word_t           dbm,
   output logic                             decValid,
   output ksCromPkg::dbusSel_t              decSel,
   output ksDataPkg::ramAddr_t              decRamAddr,
   output logic                             decRamWrite,
   output logic                             decForceRamfile,
   output logic [0:2]                       decPiReqPri,
   output ksDataPkg::vmaWord_t              decVma,
   output ksDataPkg::pcFlags_t              decPcFlags,
   output ksDataPkg::word_t                 decDp,
   output ksDataPkg::word_t                 decDbm
);

   ksCromPkg::cromAddr_t microAddr;
   logic                 noForce;
   logic                 forceRamfile;
   logic                 accept;

   // Input transfer happens only when downstream can move
   assign accept = advance && inValid;

   //////////////////////////////
   // Force ramfile
   //////////////////////////////

   assign microAddr = crom[ksCromPkg::cromAddrLsb -: ksCromPkg::cromAddrWidth];

   // Four microaddresses excluded from the AC reference case
   assign noForce = (microAddr == ksCromPkg::noForceAddr0) ||
                    (microAddr == ksCromPkg::noForceAddr1) ||
                    (microAddr == ksCromPkg::noForceAddr2) ||
                    (microAddr == ksCromPkg::noForceAddr3);

   // AC reference read or any cache-hit read
   assign forceRamfile = (vmaReg.f.acRef && vmaReg.f.read && !noForce) ||
                         (cacheHit && vmaReg.f.read);

   //////////////////////////////
   // Decode register
   //////////////////////////////

   // Empties or refills only on advance
   always_ff @(posedge clk)
   begin
      if (rst)
         decValid <= 1'b0;
      else if (advance)
         decValid <= inValid;
   end

   // Payload captured on accept
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         decSel          <= crom[ksCromPkg::cromDbusSel +: ksCromPkg::cromSelWidth];
         decRamAddr      <= crom[ksCromPkg::cromRamAddr +: ksDataPkg::ramAddrWidth];
         decRamWrite     <= crom[ksCromPkg::cromRamWrite];
         decForceRamfile <= forceRamfile;
         decPiReqPri     <= piReqPri;
         decVma          <= vmaReg;
         decPcFlags      <= pcFlags;
         decDp           <= dp;
         decDbm          <= dbm;
      end
   end

   // Held item must not change under a stall from the result stage
   holdWhileStalled : assert property (@(posedge clk) disable iff (rst)
      decValid && !advance |=> decValid && $stable(decSel) && $stable(decRamAddr) &&
         $stable(decRamWrite) && $stable(decForceRamfile) && $stable(decDp) &&
         $stable(decDbm) && $stable(decVma) && $stable(decPcFlags) &&
         $stable(decPiReqPri));

endmodule

`default_nettype wire

// File: src/ramFile.sv
`default_nettype none

module ramFile
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire  ksDataPkg::ramAddr_t rdAddr,
   output ksDataPkg::word_t     rdData,
   input  wire                  wrEn,
   input  wire  ksDataPkg::ramAddr_t wrAddr,
   input  wire  ksDataPkg::word_t    wrData
);

   //////////////////////////////
   // Storage
   //////////////////////////////

   ksDataPkg::word_t mem [0:ksDataPkg::ramDepth-1];

   // Whole file starts at zero
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < ksDataPkg::ramDepth; i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (wrEn)
      begin
         mem[wrAddr] <= wrData;
      end
   end

   //////////////////////////////
   // Read port
   //////////////////////////////

   // Combinational, sees a write only after its edge
   assign rdData = mem[rdAddr];

   // Result stage must stay quiet while the pipe is held in reset
   noWriteInReset : assert property (@(posedge clk)
      rst |-> !wrEn);

endmodule

`default_nettype wire

// File: src/dbusSelect.sv
`default_nettype none

module dbusSelect
(
   input  wire  ksCromPkg::dbusSel_t decSel,
   input  wire                       decForceRamfile,
   input  wire  [0:2]                decPiReqPri,
   input  wire  ksDataPkg::vmaWord_t decVma,
   input  wire  ksDataPkg::pcFlags_t decPcFlags,
   input  wire  ksDataPkg::word_t    decDp,
   input  wire  ksDataPkg::word_t    decDbm,
   input  wire  ksDataPkg::word_t    ramData,
   output ksDataPkg::word_t          selDbus
);

   ksDataPkg::word_t flagsWord;
   ksDataPkg::word_t dbmOrRam;

   //////////////////////////////
   // Flags word
   //////////////////////////////

   // PC flags in left half
   // Then a zero, the PI priority and four ones
   // Low ten VMA bits fill the rest
   assign flagsWord = {decPcFlags,
                       1'b0,
                       decPiReqPri,
                       4'b1111,
                       decVma.raw[26:35]};

   //////////////////////////////
   // DBM path
   //////////////////////////////

   // Ramfile stands in for memory on forced reads
   assign dbmOrRam = decForceRamfile ? ramData : decDbm;

   //////////////////////////////
   // Source mux
   //////////////////////////////

   always_comb
   begin
      unique case (decSel)
         ksCromPkg::dbusSelFlags:
            selDbus = flagsWord;
         ksCromPkg::dbusSelDp:
            selDbus = decDp;
         ksCromPkg::dbusSelRamfile:
            selDbus = ramData;
         ksCromPkg::dbusSelDbm:
            selDbus = dbmOrRam;
         default:
            selDbus = decDbm;
      endcase
   end

endmodule

`default_nettype wire

// File: src/dbusResult.sv
`default_nettype none

module dbusResult
(
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       decValid,
   input  wire  ksDataPkg::ramAddr_t decRamAddr,
   input  wire                       decRamWrite,
   input  wire  ksDataPkg::word_t    selDbus,
   input  wire                       outReady,
   output logic                      advance,
   output logic                      outValid,
   output ksDataPkg::word_t          outDbus,
   output logic                      wrEn,
   output ksDataPkg::ramAddr_t       wrAddr,
   output ksDataPkg::word_t          wrData
);

   logic load;

   //////////////////////////////
   // Pipeline control
   //////////////////////////////

   // Move when the output slot is free or being drained
   assign advance = !outValid || outReady;

   // Item from decode enters the result register
   assign load = advance && decValid;

   //////////////////////////////
   // Result register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         outValid <= 1'b0;
      else if (advance)
         outValid <= decValid;
   end

   always_ff @(posedge clk)
   begin
      if (load)
         outDbus <= selDbus;
   end

   // Write-back lands on the same edge as the load
   assign wrEn   = load && decRamWrite;
   assign wrAddr = decRamAddr;
   assign wrData = selDbus;

   // Output empty right after reset
   emptyAfterReset : assert property (@(posedge clk)
      rst |=> !outValid);

   // Back-pressure holds the offered word
   holdOutput : assert property (@(posedge clk) disable iff (rst)
      outValid && !outReady |=> outValid && $stable(outDbus));

endmodule

`default_nettype wire

// File: src/ksDbusPath.sv
`default_nettype none

module ksDbusPath
(
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             inValid,
   output logic                            inReady,
   input  wire  [0:ksCromPkg::cromWidth-1] crom,
   input  wire                             cacheHit,
   input  wire  [0:2]                      piReqPri,
   input  wire  ksDataPkg::vmaWord_t       vmaReg,
   input  wire  ksDataPkg::pcFlags_t       pcFlags,
   input  wire  ksDataPkg::word_t          dp,
   input  wire  ksDataPkg::word_t          dbm,
   output logic                            outValid,
   input  wire                             outReady,
   output ksDataPkg::word_t                outDbus
);

   // Shared stall
   logic advance;

   // Decode register outputs
   logic                decValid;
   ksCromPkg::dbusSel_t decSel;
   ksDataPkg::ramAddr_t decRamAddr;
   logic                decRamWrite;
   logic                decForceRamfile;
   logic [0:2]          decPiReqPri;
   ksDataPkg::vmaWord_t decVma;
   ksDataPkg::pcFlags_t decPcFlags;
   ksDataPkg::word_t    decDp;
   ksDataPkg::word_t    decDbm;

   // Ramfile ports and execute result
   ksDataPkg::word_t    ramData;
   ksDataPkg::word_t    selDbus;
   logic                wrEn;
   ksDataPkg::ramAddr_t wrAddr;
   ksDataPkg::word_t    wrData;

   // Accept input whenever the pipe moves
   assign inReady = advance;

   //////////////////////////////
   // Stages
   //////////////////////////////

   dbusDecode decode0
   (
      .clk(clk), .rst(rst), .advance(advance), .inValid(inValid),
      .crom(crom), .cacheHit(cacheHit), .piReqPri(piReqPri), .vmaReg(vmaReg),
      .pcFlags(pcFlags), .dp(dp), .dbm(dbm),
      .decValid(decValid), .decSel(decSel), .decRamAddr(decRamAddr),
      .decRamWrite(decRamWrite), .decForceRamfile(decForceRamfile),
      .decPiReqPri(decPiReqPri), .decVma(decVma), .decPcFlags(decPcFlags),
      .decDp(decDp), .decDbm(decDbm)
   );

   // Read address follows the item in decode
   ramFile ram0
   (
      .clk(clk), .rst(rst), .rdAddr(decRamAddr), .rdData(ramData),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

   dbusSelect select0
   (
      .decSel(decSel), .decForceRamfile(decForceRamfile),
      .decPiReqPri(decPiReqPri), .decVma(decVma), .decPcFlags(decPcFlags),
      .decDp(decDp), .decDbm(decDbm), .ramData(ramData), .selDbus(selDbus)
   );

   dbusResult result0
   (
      .clk(clk), .rst(rst), .decValid(decValid), .decRamAddr(decRamAddr),
      .decRamWrite(decRamWrite), .selDbus(selDbus), .outReady(outReady),
      .advance(advance), .outValid(outValid), .outDbus(outDbus),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

endmodule

`default_nettype wire

// File: sim/ksDbusPathTb.sv
`default_nettype none

module ksDbusPathTb;

   localparam int randomItems = 400;
   localparam int totalItems  = ksDataPkg::ramDepth + randomItems;
   localparam int waitLimit   = 200;

   logic                clk;
   logic                rst;
   logic                inValid;
   logic                inReady;
   logic [0:23]         crom;
   logic                cacheHit;
   logic [0:2]          piReqPri;
   ksDataPkg::vmaWord_t vmaReg;
   ksDataPkg::pcFlags_t pcFlags;
   ksDataPkg::word_t    dp;
   ksDataPkg::word_t    dbm;
   logic                outValid;
   logic                outReady;
   ksDataPkg::word_t    outDbus;

   // Reference model state
   ksDataPkg::word_t    ramModel [0:ksDataPkg::ramDepth-1];
   ksDataPkg::word_t    expQ [$];
   ksDataPkg::word_t    headWord;
   ksDataPkg::word_t    refWord;
   logic                qEmpty     = 1'b1;
   int                  sentCount  = 0;
   int                  doneCount  = 0;
   logic [31:0]         stimState  = 32'd97297;
   logic [31:0]         readyState = 32'd97297;

   ksDbusPath dut0
   (
      .clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .crom(crom),
      .cacheHit(cacheHit), .piReqPri(piReqPri), .vmaReg(vmaReg), .pcFlags(pcFlags),
      .dp(dp), .dbm(dbm), .outValid(outValid), .outReady(outReady), .outDbus(outDbus)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function logic [15:0] stimRand();
      stimState = lcgNext(stimState);
      return stimState[31:16];
   endfunction

   function ksDataPkg::word_t randWord();
      logic [15:0] hi;
      logic [15:0] mid;
      logic [15:0] lo;
      hi  = stimRand();
      mid = stimRand();
      lo  = stimRand();
      return {hi[3:0], mid, lo};
   endfunction

   // Big-endian microword with spare bits 19-23 left zero
   function automatic logic [0:23] makeCrom(input logic [0:11] addr, input logic [0:1] sel,
         input logic [0:3] ra, input logic wr);
      return {addr, sel, ra, wr, 5'b0};
   endfunction

   // Expected DBUS word for the item now on the inputs
   function automatic ksDataPkg::word_t expectDbus(input logic [0:23] c,
         input ksDataPkg::word_t ramWord);
      logic excluded;
      logic useRam;
      excluded = c[0:11] inside {ksCromPkg::noForceAddr0, ksCromPkg::noForceAddr1,
                                 ksCromPkg::noForceAddr2, ksCromPkg::noForceAddr3};
      useRam = (vmaReg.f.acRef && vmaReg.f.read && !excluded) || (cacheHit && vmaReg.f.read);
      case (c[12:13])
         ksCromPkg::dbusSelFlags:
            return {pcFlags, 1'b0, piReqPri, 4'b1111, vmaReg.raw[26:35]};
         ksCromPkg::dbusSelDp:
            return dp;
         ksCromPkg::dbusSelRamfile:
            return ramWord;
         default:
            return useRam ? ramWord : dbm;
      endcase
   endfunction

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1);
   endtask

   // Offer one item and hold it until the DUT takes it
   task automatic offerItem(input logic [0:23] c, input logic acRead);
      ksDataPkg::vmaWord_t v;
      ksDataPkg::word_t    w;
      logic [15:0]         r;
      int                  waited;
      v.raw = randWord();
      w     = randWord();
      r     = stimRand();
      if (acRead)
      begin
         v.f.read  = 1'b1;
         v.f.acRef = 1'b1;
      end
      crom     <= c;
      vmaReg   <= v;
      pcFlags  <= w[0:17];
      cacheHit <= r[0];
      piReqPri <= r[3:1];
      dp       <= randWord();
      dbm      <= randWord();
      inValid  <= 1'b1;
      waited = 0;
      @(posedge clk);
      while (!inReady)
      begin
         waited++;
         if (waited > waitLimit)
            stopOnError("Timeout, input transfer never accepted");
         @(posedge clk);
      end
   endtask

   task automatic offerRandomItem();
      logic [15:0] r;
      logic [15:0] a;
      logic [0:11] addr;
      r    = stimRand();
      a    = stimRand();
      addr = a[11:0];
      // Quarter of the items sit on an excluded microaddress
      if (r[15:14] == 2'b00)
         addr = (r[13:12] == 2'd0) ? ksCromPkg::noForceAddr0 :
                (r[13:12] == 2'd1) ? ksCromPkg::noForceAddr1 :
                (r[13:12] == 2'd2) ? ksCromPkg::noForceAddr2 : ksCromPkg::noForceAddr3;
      offerItem(makeCrom(addr, r[1:0], r[5:2], r[7:6] == 2'b00), r[15:14] == 2'b00);
      // Idle gap now and then
      if (r[10:8] == 3'd0)
      begin
         inValid <= 1'b0;
         repeat (r[12:11] + 1) @(posedge clk);
      end
   endtask

   //////////////////////////////
   // Clock, back-pressure, model
   //////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Ready high three cycles in four
   initial
   begin
      forever
      begin
         @(posedge clk);
         readyState = lcgNext(readyState);
         outReady <= readyState[31:30] != 2'b00;
      end
   end

   // Ramfile model updated in acceptance order
   always @(posedge clk)
   begin
      if (!rst && inValid && inReady)
      begin
         refWord = expectDbus(crom, ramModel[crom[14:17]]);
         if (crom[18])
            ramModel[crom[14:17]] = refWord;
         expQ.push_back(refWord);
         sentCount++;
      end
      if (!rst && outValid && outReady && expQ.size() != 0)
      begin
         void'(expQ.pop_front());
         doneCount++;
      end
      headWord <= (expQ.size() != 0) ? expQ[0] : '0;
      qEmpty   <= expQ.size() == 0;
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   afterReset : assert property (@(posedge clk) $fell(rst) |-> !outValid && inReady)
      else stopOnError("Output valid or input not ready right after reset");

   noExtraOutput : assert property (@(posedge clk) disable iff (rst)
      outValid && outReady |-> !qEmpty)
      else stopOnError("Output transfer with no item expected");

   dataMatch : assert property (@(posedge clk) disable iff (rst)
      outValid && outReady && !qEmpty |-> outDbus == headWord)
      else stopOnError($sformatf("FAIL time %0t outDbus expected %h actual %h",
                                 $time, $sampled(headWord), $sampled(outDbus)));

   // Stalled word must stay put
   holdStalled : assert property (@(posedge clk) disable iff (rst)
      outValid && !outReady |=> outValid && $stable(outDbus))
      else stopOnError("Output word changed or dropped while stalled");

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      int waited;
      rst      = 1'b1;
      inValid  = 1'b0;
      outReady = 1'b0;
      crom     = '0;
      cacheHit = 1'b0;
      piReqPri = '0;
      vmaReg   = '0;
      pcFlags  = '0;
      dp       = '0;
      dbm      = '0;
      for (int i = 0; i < ksDataPkg::ramDepth; i++)
         ramModel[i] = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // Every ramfile word reads zero after reset
      for (int i = 0; i < ksDataPkg::ramDepth; i++)
         offerItem(makeCrom(12'o0, ksCromPkg::dbusSelRamfile, i[3:0], 1'b0), 1'b0);
      for (int i = 0; i < randomItems; i++)
         offerRandomItem();
      inValid <= 1'b0;
      waited = 0;
      // Let the model count the last accepted item
      @(negedge clk);
      while (doneCount != sentCount)
      begin
         waited++;
         if (waited > waitLimit)
            stopOnError("Timeout, items left in the pipe after the last input");
         @(negedge clk);
      end
      if (sentCount == totalItems && expQ.size() == 0)
      begin
         $display("All tests passed!");
         $finish;
      end
      else
         stopOnError("Number of accepted items does not match the items sent");
   end

endmodule

`default_nettype wire

// File: ksDbusPath.f
src/ksCromPkg.sv
src/ksDataPkg.sv
src/dbusDecode.sv
src/ramFile.sv
src/dbusSelect.sv
src/dbusResult.sv
src/ksDbusPath.sv
sim/ksDbusPathTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ksDbusPathTb
RTL_TOP   ?= ksDbusPath
FILELIST  ?= ksDbusPath.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
